//--- hdl/usb_ctrl_consts.svh
// ------------------------------------------------------------
// widths and counts shared by the flash bridge controller
// include wherever an address or data width is needed
// ------------------------------------------------------------

`ifndef USB_CTRL_CONSTS_SVH
`define USB_CTRL_CONSTS_SVH

// one byte as delivered by the USB decoder
`define USB_DATA_W 8

// flash address arrives as this many bytes, first byte highest
`define USB_ADDR_BYTES 3

// full flash address
`define USB_ADDR_W (`USB_DATA_W * `USB_ADDR_BYTES)

`endif

//--- hdl/usb_ctrl_pkg.sv
// ------------------------------------------------------------
// status codes, instructions, requests and port structs of
// the flash bridge controller; modules take it by import
// ------------------------------------------------------------

`default_nettype none
`include "usb_ctrl_consts.svh"

package usb_ctrl_pkg;

	typedef enum logic [3:0] {
		DEC_NONE       = 4'b0000,
		DEC_DATA_BYTE  = 4'b0010,
		DEC_BYTE_READY = 4'b0011,
		DEC_TOK_READ   = 4'b0101,
		DEC_TOK_WRITE  = 4'b0110,
		DEC_TOK_ERASE  = 4'b0111,
		DEC_ACK_RCVD   = 4'b1000,
		DEC_NAK_RCVD   = 4'b1001,
		DEC_EOP        = 4'b1010
	} dec_status_t;

	typedef enum logic [2:0] {
		ENC_BUSY = 3'b000,
		ENC_IDLE = 3'b001,
		ENC_DONE = 3'b010
	} enc_status_t;

	typedef enum logic [2:0] {
		FL_NONE        = 3'b000,
		FL_WRITE_DONE  = 3'b010,
		FL_FAIL        = 3'b011,
		FL_PACKET_FULL = 3'b100,
		FL_ERASE_OK    = 3'b110
	} flash_status_t;

	typedef enum logic [3:0] {
		ENC_NOP       = 4'b0000,
		ENC_ACK_BAD   = 4'b0011,
		ENC_ACK       = 4'b0110,
		ENC_SEND_DATA = 4'b0111
	} enc_instr_t;

	typedef enum logic [2:0] {
		DEC_NOP    = 3'b000,
		DEC_LISTEN = 3'b001,
		DEC_FLUSH  = 3'b111
	} dec_instr_t;

	typedef enum logic [3:0] {
		REQ_NONE       = 4'b0000,
		REQ_READ       = 4'b0001,
		REQ_WRITE      = 4'b0010,
		REQ_ERASE      = 4'b0011,
		REQ_WRITE_BYTE = 4'b0101,
		REQ_ADDR_LATCH = 4'b0111,
		REQ_FETCH      = 4'b1000
	} flash_req_t;

	typedef enum logic [3:0] {
		ST_IDLE, ST_CMD, ST_TOK_ACK, ST_ADDR,
		ST_ERASE_WAIT, ST_ERASE_ACK, ST_ACK_BAD,
		ST_FETCH, ST_SEND, ST_HOST_WAIT, ST_FLUSH,
		ST_WRITE, ST_WRITE_BYTE, ST_WRITE_END
	} xfer_state_t;

	typedef struct packed {
		dec_status_t           status;
		logic [`USB_DATA_W-1:0] data;
	} usb_rx_t;

	typedef struct packed {
		enc_instr_t instr;
		logic       oe;
	} usb_tx_t;

	typedef struct packed {
		flash_req_t             request;
		logic [`USB_ADDR_W-1:0] address;
		logic                   restart;
	} flash_ctl_t;

endpackage

`default_nettype wire

//--- hdl/addr_collector.sv
// ------------------------------------------------------------
// collects the flash address bytes from the USB decoder and
// drives the latch request for two cycles after each byte
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_consts.svh"

module addr_collector
	import usb_ctrl_pkg::*;
(
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   start,
	input  usb_rx_t                rx,
	input  flash_req_t             base_req,
	output flash_req_t             request,
	output logic [`USB_ADDR_W-1:0] address,
	output logic                   done
);

	localparam int CNT_W = $clog2(`USB_ADDR_BYTES + 1);
	localparam logic [CNT_W-1:0] ADDR_BYTES = CNT_W'(`USB_ADDR_BYTES);

	logic [CNT_W-1:0] bytes_left;
	logic [1:0]       latch_cnt;
	logic             take_byte;

	// a byte only counts outside the latch phase
	assign take_byte = (bytes_left != '0) && (latch_cnt == 2'd0) &&
		(rx.status == DEC_BYTE_READY);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			bytes_left <= '0;
			latch_cnt  <= 2'd0;
		end else if (start) begin
			bytes_left <= ADDR_BYTES;
			latch_cnt  <= 2'd0;
		end else if (take_byte) begin
			bytes_left <= bytes_left - 1'b1;
			latch_cnt  <= 2'd2;
		end else if (latch_cnt != 2'd0) begin
			latch_cnt <= latch_cnt - 1'b1;
		end
	end

	// shift in at the low end so the first byte ends up on top
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			address <= '0;
		end else if (take_byte) begin
			address <= {address[`USB_ADDR_W-`USB_DATA_W-1:0], rx.data};
		end
	end

	// flash sees the original command between bytes
	assign request = (latch_cnt != 2'd0) ? REQ_ADDR_LATCH : base_req;

	// second latch cycle of the last byte
	assign done = (latch_cnt == 2'd1) && (bytes_left == '0);

endmodule

`default_nettype wire

//--- hdl/tx_sequencer.sv
// ------------------------------------------------------------
// drives one encoder instruction with output enable from a
// start strobe until the encoder reports idle or done
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tx_sequencer
	import usb_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        n_rst,
	input  logic        start,
	input  enc_instr_t  instr,
	input  enc_status_t enc_status,
	output usb_tx_t     tx,
	output logic        done
);

	logic tx_end;

	// end of transmission, only meaningful while enabled
	assign tx_end = tx.oe &&
		((enc_status == ENC_IDLE) || (enc_status == ENC_DONE));

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			tx.instr <= ENC_NOP;
			tx.oe    <= 1'b0;
		end else if (start) begin
			tx.instr <= instr;
			tx.oe    <= 1'b1;
		end else if (tx_end) begin
			tx.instr <= ENC_NOP;
			tx.oe    <= 1'b0;
		end
	end

	// lines up with the first cycle of oe low
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			done <= 1'b0;
		end else begin
			done <= tx_end;
		end
	end

endmodule

`default_nettype wire

//--- hdl/transfer_fsm.sv
// ------------------------------------------------------------
// transaction FSM of the flash bridge: token, acknowledge,
// address, then the read, write or erase data phase
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module transfer_fsm
	import usb_ctrl_pkg::*;
(
	input  logic          clk,
	input  logic          n_rst,
	input  usb_rx_t       rx,
	input  flash_status_t flash_status,
	input  logic          addr_done,
	input  logic          tx_done,
	output logic          addr_start,
	output logic          tx_start,
	output enc_instr_t    tx_instr,
	output flash_req_t    base_req,
	output dec_instr_t    dec_instr,
	output logic          restart
);

	xfer_state_t state;
	xfer_state_t next_state;
	flash_req_t  cmd;
	flash_req_t  next_cmd;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= ST_IDLE;
			cmd   <= REQ_NONE;
		end else begin
			state <= next_state;
			cmd   <= next_cmd;
		end
	end

	always_comb begin
		next_state = state;
		next_cmd   = cmd;
		addr_start = 1'b0;
		tx_start   = 1'b0;
		tx_instr   = ENC_NOP;
		case (state)
			ST_IDLE: begin
				next_state = ST_CMD;
				case (rx.status)
					DEC_TOK_READ:  next_cmd = REQ_READ;
					DEC_TOK_WRITE: next_cmd = REQ_WRITE;
					DEC_TOK_ERASE: next_cmd = REQ_ERASE;
					default:       next_state = ST_IDLE;
				endcase
			end
			ST_CMD: begin
				if (rx.status == DEC_EOP) begin
					tx_start   = 1'b1;
					tx_instr   = ENC_ACK;
					next_state = ST_TOK_ACK;
				end
			end
			ST_TOK_ACK: begin
				if (tx_done) begin
					addr_start = 1'b1;
					next_state = ST_ADDR;
				end
			end
			ST_ADDR: begin
				if (addr_done) begin
					case (cmd)
						REQ_READ:  next_state = ST_FETCH;
						REQ_WRITE: next_state = ST_WRITE;
						default:   next_state = ST_ERASE_WAIT;
					endcase
				end
			end
			ST_ERASE_WAIT: begin
				if (flash_status == FL_ERASE_OK) begin
					tx_start   = 1'b1;
					tx_instr   = ENC_ACK;
					next_state = ST_ERASE_ACK;
				end else if (flash_status == FL_FAIL) begin
					tx_start   = 1'b1;
					tx_instr   = ENC_ACK_BAD;
					next_state = ST_ACK_BAD;
				end
			end
			ST_ERASE_ACK, ST_ACK_BAD: begin
				if (tx_done) begin
					next_state = ST_IDLE;
				end
			end
			ST_FETCH: begin
				if (flash_status == FL_PACKET_FULL) begin
					tx_start   = 1'b1;
					tx_instr   = ENC_SEND_DATA;
					next_state = ST_SEND;
				end
			end
			ST_SEND: begin
				if (tx_done) begin
					next_state = ST_HOST_WAIT;
				end
			end
			ST_HOST_WAIT: begin
				if (rx.status == DEC_ACK_RCVD) begin
					next_state = ST_FLUSH;
				end else if (rx.status == DEC_NAK_RCVD) begin
					next_state = ST_IDLE;
				end
			end
			ST_FLUSH: next_state = ST_IDLE;
			// a data byte during the byte cycle keeps the request up
			ST_WRITE, ST_WRITE_BYTE: begin
				if (flash_status == FL_WRITE_DONE) begin
					next_state = ST_WRITE_END;
				end else if (flash_status == FL_FAIL) begin
					tx_start   = 1'b1;
					tx_instr   = ENC_ACK_BAD;
					next_state = ST_ACK_BAD;
				end else if (rx.status == DEC_DATA_BYTE) begin
					next_state = ST_WRITE_BYTE;
				end else begin
					next_state = ST_WRITE;
				end
			end
			ST_WRITE_END: next_state = ST_IDLE;
			default: next_state = ST_IDLE;
		endcase
	end

	// request and decoder instruction follow the state
	always_comb begin
		base_req  = REQ_NONE;
		dec_instr = DEC_NOP;
		case (state)
			ST_CMD, ST_TOK_ACK, ST_ADDR, ST_ERASE_WAIT: base_req = cmd;
			ST_FETCH: base_req = REQ_FETCH;
			ST_FLUSH: dec_instr = DEC_FLUSH;
			ST_WRITE: begin
				base_req  = REQ_WRITE;
				dec_instr = DEC_LISTEN;
			end
			ST_WRITE_BYTE: begin
				base_req  = REQ_WRITE_BYTE;
				dec_instr = DEC_LISTEN;
			end
			default: base_req = REQ_NONE;
		endcase
	end

	// erase-good ends on the acknowledge, write on the cycle after done
	assign restart = (state == ST_WRITE_END) ||
		((state == ST_ERASE_ACK) && tx_done);

endmodule

`default_nettype wire

//--- hdl/main_rcu.sv
// ------------------------------------------------------------
// main controller of the USB flash bridge, ties the transfer
// FSM to the address and transmit engines
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_consts.svh"

module main_rcu
	import usb_ctrl_pkg::*;
(
	input  logic          clk,
	input  logic          n_rst,
	input  usb_rx_t       rx,
	input  enc_status_t   enc_status,
	input  flash_status_t flash_status,
	output usb_tx_t       tx,
	output dec_instr_t    dec_instr,
	output flash_ctl_t    flash
);

	logic                   addr_start;
	logic                   addr_done;
	logic                   tx_start;
	logic                   tx_done;
	logic                   restart;
	enc_instr_t             tx_instr;
	flash_req_t             base_req;
	flash_req_t             flash_req;
	logic [`USB_ADDR_W-1:0] flash_addr;

	transfer_fsm u_fsm (
		.clk         (clk),
		.n_rst       (n_rst),
		.rx          (rx),
		.flash_status(flash_status),
		.addr_done   (addr_done),
		.tx_done     (tx_done),
		.addr_start  (addr_start),
		.tx_start    (tx_start),
		.tx_instr    (tx_instr),
		.base_req    (base_req),
		.dec_instr   (dec_instr),
		.restart     (restart)
	);

	addr_collector u_addr (
		.clk     (clk),
		.n_rst   (n_rst),
		.start   (addr_start),
		.rx      (rx),
		.base_req(base_req),
		.request (flash_req),
		.address (flash_addr),
		.done    (addr_done)
	);

	tx_sequencer u_tx (
		.clk       (clk),
		.n_rst     (n_rst),
		.start     (tx_start),
		.instr     (tx_instr),
		.enc_status(enc_status),
		.tx        (tx),
		.done      (tx_done)
	);

	assign flash = '{request: flash_req, address: flash_addr, restart: restart};

endmodule

`default_nettype wire

//--- sim/main_rcu_sva.sv
// ------------------------------------------------------------
// output rule assertions for the flash bridge controller,
// bound into the top level
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module main_rcu_sva
	import usb_ctrl_pkg::*;
(
	input logic       clk,
	input logic       n_rst,
	input usb_tx_t    tx,
	input flash_ctl_t flash
);

	// encoder never enabled without an instruction
	a_oe_has_instr: assert property (@(posedge clk) disable iff (!n_rst)
		tx.oe |-> (tx.instr != ENC_NOP))
		else $error("tx output enable high with ENC_NOP");

	a_restart_pulse: assert property (@(posedge clk) disable iff (!n_rst)
		flash.restart |=> !flash.restart)
		else $error("restart held longer than one cycle");

	// two latch cycles per address byte at most
	a_latch_len: assert property (@(posedge clk) disable iff (!n_rst)
		(flash.request == REQ_ADDR_LATCH) ##1 (flash.request == REQ_ADDR_LATCH)
		|=> (flash.request != REQ_ADDR_LATCH))
		else $error("address latch request longer than two cycles");

endmodule

bind main_rcu main_rcu_sva u_sva (
	.clk  (clk),
	.n_rst(n_rst),
	.tx   (tx),
	.flash(flash)
);

`default_nettype wire

//--- sim/main_rcu_tb.sv
// ------------------------------------------------------------
// testbench for the flash bridge controller with random read,
// write and erase transactions checked against a model
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_consts.svh"

module main_rcu_tb
	import usb_ctrl_pkg::*;
();

	localparam int N_TXNS         = 12;
	localparam int N_TESTS        = 4;
	localparam int MAX_GAP        = 3;
	localparam int MAX_BUSY       = 4;
	localparam int MAX_WR_BYTES   = 4;
	localparam int MAX_TXN_CYCLES = 80;
	localparam int CLK_PERIOD     = 20;

	logic          clk;
	logic          n_rst;
	usb_rx_t       rx;
	enc_status_t   enc_status;
	flash_status_t flash_status;
	usb_tx_t       tx;
	dec_instr_t    dec_instr;
	flash_ctl_t    flash;

	int    seed = 32;
	int    errors;
	int    checks;
	int    test_errors;
	int    test_checks;
	string test_name;

	main_rcu u_main_rcu (
		.clk         (clk),
		.n_rst       (n_rst),
		.rx          (rx),
		.enc_status  (enc_status),
		.flash_status(flash_status),
		.tx          (tx),
		.dec_instr   (dec_instr),
		.flash       (flash)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// watchdog sized from the worst transaction
	initial begin
		#((N_TESTS * N_TXNS * MAX_TXN_CYCLES + 40) * CLK_PERIOD);
		$display("timeout: the DUT stopped answering, run aborted");
		$display("TESTBENCH FAILED");
		$finish;
	end

	function automatic int rand_upto(input int max);
		return int'($unsigned($random(seed)) % (max + 1));
	endfunction

	// token code and data phase request per command
	function automatic dec_status_t token_for(input flash_req_t cmd);
		case (cmd)
			REQ_READ:  return DEC_TOK_READ;
			REQ_WRITE: return DEC_TOK_WRITE;
			default:   return DEC_TOK_ERASE;
		endcase
	endfunction

	function automatic flash_req_t phase_request(input flash_req_t cmd);
		if (cmd == REQ_READ)
			return REQ_FETCH;
		return cmd;
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		test_checks++;
		assert (exp === act) else begin
			$display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic drive_rx(input dec_status_t st, input logic [7:0] data);
		rx.status = st;
		rx.data   = data;
	endtask

	// idle cycles with the request and decoder instruction held
	task automatic hold(input int n, input flash_req_t req, input dec_instr_t din);
		repeat (n) begin
			@(negedge clk);
			check("held request", 32'(req), 32'(flash.request));
			check("held dec_instr", 32'(din), 32'(dec_instr));
		end
	endtask

	// encoder stays busy a while, then reports the end
	task automatic run_encoder(input enc_instr_t instr);
		int busy;
		busy = rand_upto(MAX_BUSY);
		check("tx oe", 32'd1, 32'(tx.oe));
		check("tx instr", 32'(instr), 32'(tx.instr));
		repeat (busy) begin
			@(negedge clk);
			check("tx oe busy", 32'd1, 32'(tx.oe));
			check("tx instr busy", 32'(instr), 32'(tx.instr));
		end
		enc_status = (rand_upto(1) == 0) ? ENC_IDLE : ENC_DONE;
		@(negedge clk);
		enc_status = ENC_BUSY;
		check("tx oe drop", 32'd0, 32'(tx.oe));
		check("tx instr drop", 32'(ENC_NOP), 32'(tx.instr));
	endtask

	task automatic run_transaction(input flash_req_t cmd);
		logic [`USB_ADDR_W-1:0] addr_exp;
		logic [`USB_DATA_W-1:0] b;
		int                     i;
		int                     n_wr;
		bit                     good;
		addr_exp = '0;
		hold(rand_upto(MAX_GAP), REQ_NONE, DEC_NOP);
		drive_rx(token_for(cmd), 8'($random(seed)));
		@(negedge clk);
		drive_rx(DEC_NONE, 8'h00);
		check("command request", 32'(cmd), 32'(flash.request));
		hold(rand_upto(MAX_GAP), cmd, DEC_NOP);
		drive_rx(DEC_EOP, 8'h00);
		@(negedge clk);
		drive_rx(DEC_NONE, 8'h00);
		run_encoder(ENC_ACK);
		hold(1, cmd, DEC_NOP);

		for (i = 0; i < `USB_ADDR_BYTES; i++) begin
			hold(rand_upto(MAX_GAP), cmd, DEC_NOP);
			b = 8'($random(seed));
			// first byte goes to the top byte lane
			addr_exp[(`USB_ADDR_BYTES - 1 - i) * `USB_DATA_W +: `USB_DATA_W] = b;
			drive_rx(DEC_BYTE_READY, b);
			@(negedge clk);
			drive_rx(DEC_NONE, 8'h00);
			check("latch 1", 32'(REQ_ADDR_LATCH), 32'(flash.request));
			@(negedge clk);
			check("latch 2", 32'(REQ_ADDR_LATCH), 32'(flash.request));
			@(negedge clk);
			if (i < `USB_ADDR_BYTES - 1)
				check("between bytes", 32'(cmd), 32'(flash.request));
		end
		check("address", 32'(addr_exp), 32'(flash.address));
		check("phase request", 32'(phase_request(cmd)), 32'(flash.request));

		good = rand_upto(1) == 1;
		case (cmd)
			REQ_ERASE: begin
				hold(rand_upto(MAX_GAP), REQ_ERASE, DEC_NOP);
				flash_status = good ? FL_ERASE_OK : FL_FAIL;
				@(negedge clk);
				flash_status = FL_NONE;
				run_encoder(good ? ENC_ACK : ENC_ACK_BAD);
				check("erase restart", 32'(good), 32'(flash.restart));
				@(negedge clk);
				check("restart end", 32'd0, 32'(flash.restart));
			end
			REQ_READ: begin
				hold(rand_upto(MAX_GAP), REQ_FETCH, DEC_NOP);
				flash_status = FL_PACKET_FULL;
				@(negedge clk);
				flash_status = FL_NONE;
				run_encoder(ENC_SEND_DATA);
				hold(1 + rand_upto(MAX_GAP), REQ_NONE, DEC_NOP);
				drive_rx(good ? DEC_ACK_RCVD : DEC_NAK_RCVD, 8'h00);
				@(negedge clk);
				drive_rx(DEC_NONE, 8'h00);
				check("host reply", 32'(good ? DEC_FLUSH : DEC_NOP), 32'(dec_instr));
				if (good)
					hold(1, REQ_NONE, DEC_NOP);
			end
			default: begin
				n_wr = rand_upto(MAX_WR_BYTES);
				for (i = 0; i < n_wr; i++) begin
					hold(rand_upto(MAX_GAP), REQ_WRITE, DEC_LISTEN);
					drive_rx(DEC_DATA_BYTE, 8'($random(seed)));
					@(negedge clk);
					drive_rx(DEC_NONE, 8'h00);
					check("write byte", 32'(REQ_WRITE_BYTE), 32'(flash.request));
				end
				hold(1 + rand_upto(MAX_GAP), REQ_WRITE, DEC_LISTEN);
				flash_status = good ? FL_WRITE_DONE : FL_FAIL;
				@(negedge clk);
				flash_status = FL_NONE;
				if (good) begin
					check("write restart", 32'd1, 32'(flash.restart));
				end else begin
					run_encoder(ENC_ACK_BAD);
					check("write fail restart", 32'd0, 32'(flash.restart));
				end
				@(negedge clk);
				check("restart end", 32'd0, 32'(flash.restart));
			end
		endcase
		check("back to idle", 32'(REQ_NONE), 32'(flash.request));
	endtask

	// kind 3 mixes all commands
	task automatic run_test(input string name, input int kind);
		flash_req_t cmd;
		int         k;
		test_name   = name;
		test_errors = 0;
		test_checks = 0;
		for (k = 0; k < N_TXNS; k++) begin
			case ((kind == 3) ? rand_upto(2) : kind)
				0:       cmd = REQ_ERASE;
				1:       cmd = REQ_READ;
				default: cmd = REQ_WRITE;
			endcase
			run_transaction(cmd);
		end
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
	endtask

	task automatic check_reset_state();
		check("tx oe", 32'd0, 32'(tx.oe));
		check("tx instr", 32'(ENC_NOP), 32'(tx.instr));
		check("request", 32'(REQ_NONE), 32'(flash.request));
		check("restart", 32'd0, 32'(flash.restart));
		check("dec_instr", 32'(DEC_NOP), 32'(dec_instr));
		check("address", 32'd0, 32'(flash.address));
	endtask

	initial begin
		n_rst        = 1'b0;
		rx.status    = DEC_NONE;
		rx.data      = 8'h00;
		enc_status   = ENC_BUSY;
		flash_status = FL_NONE;
		errors       = 0;
		checks       = 0;
		test_name    = "reset";
		test_errors  = 0;
		test_checks  = 0;
		repeat (8) @(negedge clk);
		check_reset_state();
		n_rst = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_reset_state();
		end
		$display("test reset: %0d checks, %0d errors", test_checks, test_errors);

		run_test("erase", 0);
		run_test("read", 1);
		run_test("write", 2);
		run_test("mixed", 3);

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/usb_ctrl_pkg.sv
hdl/addr_collector.sv
hdl/tx_sequencer.sv
hdl/transfer_fsm.sv
hdl/main_rcu.sv
sim/main_rcu_sva.sv
sim/main_rcu_tb.sv

//--- Makefile
TOP = main_rcu_tb

.PHONY: all run build lint clean

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)
	verilator --lint-only -f build.f --top-module main_rcu \
		hdl/usb_ctrl_pkg.sv hdl/addr_collector.sv hdl/tx_sequencer.sv \
		hdl/transfer_fsm.sv hdl/main_rcu.sv

clean:
	rm -rf obj_dir
